// File: build.f
+incdir+verilog
verilog/slot_stream_pkg.sv
verilog/window_fsm.sv
verilog/slot_counter.sv
verilog/slot_ram.sv
verilog/window_sum.sv
verilog/slot_stream_top.sv
tests/slot_stream_assert.sv
tests/slot_stream_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the slot stream simulation with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal -f build.f --top-module slot_stream_tb \
    -o slot_stream_sim || exit 1

./obj_dir/slot_stream_sim | tee /dev/stderr | grep -x "=== PASS ===" > /dev/null \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

// File: tests/slot_stream_assert.sv
// Stream protocol assertions
`include "slot_stream_defines.svh"

module slot_stream_assert (
    input logic                      clk,
    input logic                      rst,
    input logic                      en,
    input slot_stream_pkg::seq_state_e state,
    input logic                      window_end,
    input slot_stream_pkg::beat_t    beat,
    input slot_stream_pkg::summary_t summary
);
    import slot_stream_pkg::*;

    // Only the last drain beat may still sit in the output register
    beat_in_off: assert property (@(posedge clk) disable iff (rst)
        (state == SEQ_OFF && beat.valid) |-> ($past(state) == SEQ_DRAIN))
        else $error("beat.valid high in SEQ_OFF without a drain just before");

    // Summary strobe trails window_end by one cycle and covers a whole window
    summary_after_end: assert property (@(posedge clk) disable iff (rst)
        summary.valid |-> ($past(window_end) && summary.beats == `SS_WINDOW_LEN))
        else $error("summary.valid without window_end before or with a partial window");

    // Off is left only on enable
    stay_off: assert property (@(posedge clk) disable iff (rst)
        (state == SEQ_OFF && !en) |=> (state == SEQ_OFF))
        else $error("sequencer left SEQ_OFF while en was low");

endmodule

// File: tests/slot_stream_tb.sv
// Slot stream testbench
`include "slot_stream_defines.svh"

module slot_stream_tb;
    import slot_stream_pkg::*;

    localparam int interim    = `SS_INTERIM_CYCLES;
    localparam int slot_count = `SS_SLOT_COUNT;
    localparam int window_len = `SS_WINDOW_LEN;
    localparam int wait_limit = 200;

    logic     clk;
    logic     rst;
    logic     en;
    ram_wr_t  wr;
    beat_t    beat;
    summary_t summary;

    integer seed;
    int     test_errors;
    int     total_errors;
    int     tests_run;
    int     tests_failed;
    int     n_beats;
    int     n_sums;
    int     n_collide;

    // Reference model
    seq_state_e            m_state;
    logic [`SS_RAMP_W-1:0] m_ramp;
    logic [`SS_SLOT_W-1:0] m_slot;
    logic [`SS_DATA_W-1:0] m_mem [`SS_SLOT_COUNT];
    logic [`SS_SLOT_W:0]   m_acc_beats;
    logic [`SS_SUM_W-1:0]  m_acc_sum;
    beat_t                 m_beat;
    summary_t              m_sum;

    slot_stream_top dut0 (
        .clk     (clk),
        .rst     (rst),
        .en      (en),
        .wr      (wr),
        .beat    (beat),
        .summary (summary)
    );

    bind slot_stream_top slot_stream_assert u_assert (
        .clk        (clk),
        .rst        (rst),
        .en         (en),
        .state      (state),
        .window_end (window_end),
        .beat       (beat),
        .summary    (summary)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    // ------------------------------
    // Model
    task automatic model_reset;
        m_state     = SEQ_OFF;
        m_ramp      = '0;
        m_slot      = '0;
        m_acc_beats = '0;
        m_acc_sum   = '0;
        m_beat      = '0;
        m_sum       = '0;
        for (int i = 0; i < slot_count; i++) begin
            m_mem[i] = '0;
        end
    endtask

    // One clock edge, with en and wr as the DUT samples them
    task automatic model_edge;
        logic counting;
        logic act;
        logic wend;

        counting = (m_state == SEQ_COUNT) || (m_state == SEQ_DRAIN);
        act      = counting && (m_slot < window_len);
        wend     = counting && (m_slot == window_len);

        // Totals gather the beats already shown on the output
        if (m_state == SEQ_BOOT || m_state == SEQ_OFF) begin
            m_acc_beats = '0;
            m_acc_sum   = '0;
        end else begin
            if (m_sum.valid) begin
                m_acc_beats = '0;
                m_acc_sum   = '0;
            end
            if (m_beat.valid) begin
                m_acc_beats = m_acc_beats + 1'b1;
                m_acc_sum   = m_acc_sum + `SS_SUM_W'(m_beat.data);
            end
        end
        m_sum.valid = wend;
        m_sum.beats = m_acc_beats;
        m_sum.sum   = m_acc_sum;

        // Old word wins over a write in the same cycle
        m_beat.valid = act;
        m_beat.slot  = m_slot;
        m_beat.data  = m_mem[m_slot];
        if (wr.valid) begin
            m_mem[wr.addr] = wr.data;
        end

        if (!counting || m_slot == slot_count - 1) begin
            m_slot = '0;
        end else begin
            m_slot = m_slot + 1'b1;
        end

        case (m_state)
            SEQ_OFF: begin
                if (en) begin
                    m_state = SEQ_BOOT;
                    m_ramp  = '0;
                end
            end
            SEQ_BOOT: begin
                if (!en) begin
                    m_state = SEQ_DRAIN;
                end else if (m_ramp == interim - 1) begin
                    m_state = SEQ_COUNT;
                end else begin
                    m_ramp = m_ramp + 1'b1;
                end
            end
            SEQ_COUNT: begin
                if (!en) begin
                    m_state = SEQ_DRAIN;
                end
            end
            default: begin
                if (en) begin
                    m_state = SEQ_BOOT;
                end else if (m_ramp == 0) begin
                    m_state = SEQ_OFF;
                end else begin
                    m_ramp = m_ramp - 1'b1;
                end
            end
        endcase
    endtask

    // ------------------------------
    // Checks and reporting
    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            test_errors++;
            $display("FAIL time %0t %s: got %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_outputs;
        if (beat.valid !== m_beat.valid) begin
            test_errors++;
            if (m_beat.valid) begin
                $display("Missing beat at time %0t, slot %0d was due", $time, m_beat.slot);
            end else begin
                $display("Extra beat at time %0t on slot %0d", $time, beat.slot);
            end
        end else if (m_beat.valid) begin
            n_beats++;
            check_value("beat.slot", 32'(beat.slot), 32'(m_beat.slot));
            check_value("beat.data", 32'(beat.data), 32'(m_beat.data));
            if (beat.slot >= window_len) begin
                test_errors++;
                $display("Beat at time %0t on slot %0d is outside the window",
                         $time, beat.slot);
            end
        end
        if (summary.valid !== m_sum.valid) begin
            test_errors++;
            if (m_sum.valid) begin
                $display("Missing summary at time %0t, %0d beats were due",
                         $time, m_sum.beats);
            end else begin
                $display("Extra summary at time %0t with %0d beats", $time, summary.beats);
            end
        end else if (m_sum.valid) begin
            n_sums++;
            check_value("summary.beats", 32'(summary.beats), 32'(m_sum.beats));
            check_value("summary.sum", 32'(summary.sum), 32'(m_sum.sum));
        end
    endtask

    // Random host write, half the cycles, some aimed at the slot read next
    task automatic drive_write;
        if ($random(seed) & 1) begin
            wr.valid = 1'b1;
            if (($random(seed) & 3) == 0) begin
                wr.addr = m_slot;
            end else begin
                wr.addr = `SS_SLOT_W'($random(seed));
            end
            wr.data = `SS_DATA_W'($random(seed));
            if (m_state == SEQ_COUNT && wr.addr == m_slot && m_slot < window_len) begin
                n_collide++;
            end
        end else begin
            wr = '0;
        end
    endtask

    // Edge, model update, compare, then new inputs
    task automatic step;
        @(posedge clk);
        model_edge();
        #1;
        check_outputs();
        #1;
        drive_write();
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        total_errors += test_errors;
        if (test_errors != 0) begin
            tests_failed++;
            $display("Test %0d %s: %0d errors", tests_run, name, test_errors);
        end else begin
            $display("Test %0d %s: ok", tests_run, name);
        end
        test_errors = 0;
    endtask

    task automatic finish_run;
        $display("Tests %0d, failed %0d, errors %0d, beats %0d, summaries %0d, collisions %0d",
                 tests_run, tests_failed, total_errors, n_beats, n_sums, n_collide);
        if (total_errors == 0 && tests_failed == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    endtask

    task automatic timed_out(input string what);
        $display("Timeout at time %0t while waiting for %s", $time, what);
        total_errors += test_errors + 1;
        finish_run();
    endtask

    // ------------------------------
    // Waits
    task automatic wait_for_beat(output int cycles);
        cycles = 0;
        do begin
            if (cycles >= wait_limit) begin
                timed_out("a beat");
            end
            step();
            cycles++;
        end while (!beat.valid);
    endtask

    task automatic wait_for_frame_start;
        int cycles;
        cycles = 0;
        while (m_state != SEQ_COUNT || m_slot != 0) begin
            if (cycles >= wait_limit) begin
                timed_out("slot 0 while counting");
            end
            step();
            cycles++;
        end
    endtask

    // ------------------------------
    // Tests
    initial begin
        int cycles;
        int seen;
        int drain_len;
        int start_beats;
        int start_sums;
        int pulse;
        int gap;
        int run;

        seed         = 56;
        test_errors  = 0;
        total_errors = 0;
        tests_run    = 0;
        tests_failed = 0;
        n_beats      = 0;
        n_sums       = 0;
        n_collide    = 0;
        rst = 1'b1;
        en  = 1'b0;
        wr  = '0;
        model_reset();
        repeat (8) @(posedge clk);
        #2;
        rst = 1'b0;

        repeat (50) begin
            step();
            if (beat.valid || summary.valid) begin
                test_errors++;
                $display("Strobe at time %0t while en is low", $time);
            end
        end
        finish_test("idle after reset");

        // Boot ramp, then the first beat on slot 0
        en = 1'b1;
        step();
        wait_for_beat(cycles);
        check_value("first beat latency", cycles, interim + 1);
        check_value("beat.slot", 32'(beat.slot), 0);
        finish_test("boot latency");

        start_beats = n_beats;
        repeat (4 * slot_count) step();
        check_value("beats in four frames", n_beats - start_beats, 4 * window_len);
        finish_test("beat data");

        seen = 0;
        repeat (3 * slot_count) begin
            step();
            if (summary.valid) begin
                seen++;
                check_value("summary.beats", 32'(summary.beats), window_len);
            end
        end
        check_value("summaries in three frames", seen, 3);
        finish_test("window summaries");

        // Drop at slot 0 so the whole drain lands inside the window
        wait_for_frame_start();
        en = 1'b0;
        step();
        seen = 0;
        repeat (4 * interim) begin
            step();
            if (beat.valid) begin
                seen++;
            end
            if (summary.valid) begin
                test_errors++;
                $display("Summary at time %0t for a window cut by the drain", $time);
            end
        end
        check_value("beats during drain", seen, interim);

        // Re-enable two cycles into the drain
        en = 1'b1;
        wait_for_frame_start();
        en = 1'b0;
        drain_len = 2;
        repeat (drain_len) step();
        en = 1'b1;
        step();
        wait_for_beat(cycles);
        check_value("restart latency", cycles, drain_len + 1);
        check_value("beat.slot", 32'(beat.slot), 0);
        finish_test("drain and restart");

        // Long pulses, short ones that drop during boot, short gaps into drain
        start_beats = n_beats;
        start_sums  = n_sums;
        run = 0;
        while (run < 3000) begin
            if (($random(seed) & 3) == 0) begin
                pulse = 1 + ($unsigned($random(seed)) % 4);
            end else begin
                pulse = 10 + ($unsigned($random(seed)) % 51);
            end
            gap = 1 + ($unsigned($random(seed)) % 20);
            en  = 1'b1;
            repeat (pulse) step();
            en = 1'b0;
            repeat (gap) step();
            run += pulse + gap;
        end
        if (n_beats == start_beats || n_sums == start_sums) begin
            test_errors++;
            $display("Random run produced no beats or no summaries");
        end
        if (n_collide == 0) begin
            test_errors++;
            $display("No write ever collided with a read of the same slot");
        end
        finish_test("random run");

        finish_run();
    end

endmodule

// File: verilog/slot_counter.sv
// Frame slot counter
`include "slot_stream_defines.svh"

module slot_counter (
    input  logic                        clk,
    input  logic                        rst,
    input  slot_stream_pkg::seq_state_e state,
    output logic [`SS_SLOT_W-1:0]       slot,
    output logic                        active,
    output logic                        window_end
);
    import slot_stream_pkg::*;

    localparam logic [`SS_SLOT_W-1:0] slot_last  = `SS_SLOT_W'(`SS_SLOT_COUNT - 1);
    localparam logic [`SS_SLOT_W-1:0] window_len = `SS_SLOT_W'(`SS_WINDOW_LEN);

    logic counting;

    // Slots run in count and keep running through drain
    assign counting = (state == SEQ_COUNT) || (state == SEQ_DRAIN);

    // ------------------------------
    // Slot index
    always_ff @(posedge clk) begin
        if (rst) begin
            slot <= '0;
        end else if (!counting) begin
            // Boot and off hold slot 0 so counting starts clean
            slot <= '0;
        end else if (slot == slot_last) begin
            slot <= '0;
        end else begin
            slot <= slot + 1'b1;
        end
    end

    // ------------------------------
    // Window decode
    always_comb begin
        active     = counting && (slot < window_len);
        window_end = counting && (slot == window_len);
    end

endmodule

// File: verilog/slot_ram.sv
// Slot data memory
`include "slot_stream_defines.svh"

module slot_ram (
    input  logic                     clk,
    input  logic                     rst,
    input  slot_stream_pkg::ram_wr_t wr,
    input  logic [`SS_SLOT_W-1:0]    rd_addr,
    output logic [`SS_DATA_W-1:0]    rd_data
);
    import slot_stream_pkg::*;

    logic [`SS_DATA_W-1:0] mem [`SS_SLOT_COUNT];

    // ------------------------------
    // Host write port, always accepted
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `SS_SLOT_COUNT; i++) begin
                mem[i] <= '0;
            end
        end else if (wr.valid) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // ------------------------------
    // Registered read
    // Same-slot write in this cycle is not seen, old word comes out
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

// File: verilog/slot_stream_defines.svh
// Slot stream parameters
`ifndef SLOT_STREAM_DEFINES_SVH
`define SLOT_STREAM_DEFINES_SVH

// Boot ramp length in cycles
`define SS_INTERIM_CYCLES 5

// Frame layout, window must stay shorter than the frame
`define SS_SLOT_COUNT 8
`define SS_WINDOW_LEN 6

`define SS_SLOT_W 3
`define SS_RAMP_W 3
`define SS_DATA_W 8
`define SS_SUM_W 11
`endif

// File: verilog/slot_stream_pkg.sv
// Slot stream types
`include "slot_stream_defines.svh"

package slot_stream_pkg;

    // Sequencer states, encoded as in the older timer block
    typedef enum logic [1:0] {
        SEQ_COUNT = 2'b00,
        SEQ_DRAIN = 2'b01,
        SEQ_BOOT  = 2'b10,
        SEQ_OFF   = 2'b11
    } seq_state_e;

    // ------------------------------
    // Host write into slot RAM
    typedef struct packed {
        logic                  valid;
        logic [`SS_SLOT_W-1:0] addr;
        logic [`SS_DATA_W-1:0] data;
    } ram_wr_t;

    // One data beat per active slot
    typedef struct packed {
        logic                  valid;
        logic [`SS_SLOT_W-1:0] slot;
        logic [`SS_DATA_W-1:0] data;
    } beat_t;

    // Per-window totals
    typedef struct packed {
        logic                 valid;
        logic [`SS_SLOT_W:0]  beats;
        logic [`SS_SUM_W-1:0] sum;
    } summary_t;

endpackage

// File: verilog/slot_stream_top.sv
// Slot stream sequencer top
`include "slot_stream_defines.svh"

module slot_stream_top (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      en,
    input  slot_stream_pkg::ram_wr_t  wr,
    output slot_stream_pkg::beat_t    beat,
    output slot_stream_pkg::summary_t summary
);
    import slot_stream_pkg::*;

    // ------------------------------
    // Internal wires
    seq_state_e            state;
    logic [`SS_SLOT_W-1:0] slot;
    logic                  active;
    logic                  window_end;
    logic [`SS_DATA_W-1:0] rd_data;

    // ------------------------------
    // Sequencer with its ramp counter
    window_fsm u_fsm (
        .clk   (clk),
        .rst   (rst),
        .en    (en),
        .state (state)
    );

    // Slot index and window flags
    slot_counter u_counter (
        .clk        (clk),
        .rst        (rst),
        .state      (state),
        .slot       (slot),
        .active     (active),
        .window_end (window_end)
    );

    // ------------------------------
    // Slot RAM, read at the live slot index
    slot_ram u_ram (
        .clk     (clk),
        .rst     (rst),
        .wr      (wr),
        .rd_addr (slot),
        .rd_data (rd_data)
    );

    // ------------------------------
    // Beats and window summaries
    // Read data lands one cycle after the slot, the flags are delayed to match
    window_sum u_sum (
        .clk        (clk),
        .rst        (rst),
        .state      (state),
        .active     (active),
        .window_end (window_end),
        .slot       (slot),
        .rd_data    (rd_data),
        .beat       (beat),
        .summary    (summary)
    );

endmodule

// File: verilog/window_fsm.sv
// Boot and drain sequencer
`include "slot_stream_defines.svh"

module window_fsm (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        en,
    output slot_stream_pkg::seq_state_e state
);
    import slot_stream_pkg::*;

    // Last ramp step of the boot phase
    localparam logic [`SS_RAMP_W-1:0] ramp_top = `SS_RAMP_W'(`SS_INTERIM_CYCLES - 1);

    seq_state_e             state_next;
    logic [`SS_RAMP_W-1:0] ramp;
    logic [`SS_RAMP_W-1:0] ramp_next;

    // ------------------------------
    // State and ramp registers
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= SEQ_OFF;
            ramp  <= '0;
        end else begin
            state <= state_next;
            ramp  <= ramp_next;
        end
    end

    // ------------------------------
    // Next state and ramp
    always_comb begin
        state_next = state;
        ramp_next  = ramp;
        case (state)
            SEQ_OFF: begin
                if (en) begin
                    state_next = SEQ_BOOT;
                    ramp_next  = '0;
                end
            end

            SEQ_BOOT: begin
                if (!en) begin
                    // Ramp down from wherever boot got to
                    state_next = SEQ_DRAIN;
                end else if (ramp == ramp_top) begin
                    state_next = SEQ_COUNT;
                end else begin
                    ramp_next = ramp + 1'b1;
                end
            end

            SEQ_COUNT: begin
                // Ramp sits at its top value while counting
                if (!en) begin
                    state_next = SEQ_DRAIN;
                end
            end

            SEQ_DRAIN: begin
                if (en) begin
                    // Climb back up from the current ramp value
                    state_next = SEQ_BOOT;
                end else if (ramp == '0) begin
                    state_next = SEQ_OFF;
                end else begin
                    ramp_next = ramp - 1'b1;
                end
            end

            default: begin
                state_next = SEQ_OFF;
                ramp_next  = '0;
            end
        endcase
    end

endmodule

// File: verilog/window_sum.sv
// Beat stage and window accumulator
`include "slot_stream_defines.svh"

module window_sum (
    input  logic                        clk,
    input  logic                        rst,
    input  slot_stream_pkg::seq_state_e state,
    input  logic                        active,
    input  logic                        window_end,
    input  logic [`SS_SLOT_W-1:0]       slot,
    input  logic [`SS_DATA_W-1:0]       rd_data,
    output slot_stream_pkg::beat_t      beat,
    output slot_stream_pkg::summary_t   summary
);
    import slot_stream_pkg::*;

    localparam int beats_w = `SS_SLOT_W + 1;

    logic                  act_q;
    logic                  end_q;
    logic [`SS_SLOT_W-1:0] slot_q;
    logic [beats_w-1:0]    acc_beats;
    logic [`SS_SUM_W-1:0]  acc_sum;
    logic                  clear;

    // Boot or off drops any partial window
    assign clear = (state == SEQ_BOOT) || (state == SEQ_OFF);

    // ------------------------------
    // Align flags with the RAM read
    always_ff @(posedge clk) begin
        if (rst) begin
            act_q <= 1'b0;
            end_q <= 1'b0;
        end else begin
            act_q <= active;
            end_q <= window_end;
        end
    end

    always_ff @(posedge clk) begin
        slot_q <= slot;
    end

    always_comb begin
        beat = '{valid: act_q, slot: slot_q, data: rd_data};
    end

    // ------------------------------
    // Window totals
    always_ff @(posedge clk) begin
        if (rst || clear) begin
            acc_beats <= '0;
            acc_sum   <= '0;
        end else if (end_q) begin
            // Summary goes out this cycle, restart with the current beat
            acc_beats <= beats_w'(act_q);
            acc_sum   <= act_q ? `SS_SUM_W'(rd_data) : '0;
        end else if (act_q) begin
            acc_beats <= acc_beats + 1'b1;
            acc_sum   <= acc_sum + `SS_SUM_W'(rd_data);
        end
    end

    always_comb begin
        summary = '{valid: end_q, beats: acc_beats, sum: acc_sum};
    end

endmodule
